// File: design/dual_port_ram.sv
module dual_port_ram #(
    parameter int DATA_WIDTH = ifm_buffer_pkg::DEFAULT_DATA_WIDTH,
    parameter int IFM_SIZE = ifm_buffer_pkg::DEFAULT_IFM_SIZE,
    localparam int ADDR_WIDTH = ifm_buffer_pkg::addr_width(IFM_SIZE)
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  logic                  rd_en_a,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  rd_en_b,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    output logic [DATA_WIDTH-1:0] rd_data_a,
    output logic [DATA_WIDTH-1:0] rd_data_b
);

    localparam int DEPTH = IFM_SIZE * IFM_SIZE;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // port a is shared between the write and the next-layer read.
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[addr_a] <= wr_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rd_data_a <= '0;
        else if (rd_en_a)
            rd_data_a <= mem[addr_a];
    end

    // port b only reads.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rd_data_b <= '0;
        else if (rd_en_b)
            rd_data_b <= mem[addr_b];
    end

    // the steering never gives port a to both layers in the same cycle.
    a_port_a_single_user : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wr_en && rd_en_a)
    )
    else
        $error("port a written and read on the same edge");

endmodule

// File: design/ifm_bank_group.sv
module ifm_bank_group #(
    parameter int DATA_WIDTH = ifm_buffer_pkg::DEFAULT_DATA_WIDTH,
    parameter int IFM_SIZE = ifm_buffer_pkg::DEFAULT_IFM_SIZE,
    parameter int NUMBER_OF_IFM = ifm_buffer_pkg::DEFAULT_NUMBER_OF_IFM,
    parameter int NUMBER_OF_UNITS = ifm_buffer_pkg::DEFAULT_NUMBER_OF_UNITS,
    parameter int GROUP_INDEX = 0,
    localparam int ADDR_WIDTH = ifm_buffer_pkg::addr_width(IFM_SIZE)
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  logic                  rd_en_a,
    input  logic                  rd_en_b,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  logic [DATA_WIDTH-1:0] wr_data [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] rd_data_a [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] rd_data_b [NUMBER_OF_UNITS]
);

    // all lanes of a group move in lockstep on the same addresses.
    for (genvar u = 0; u < NUMBER_OF_UNITS; u++)
    begin : g_lane
        localparam int MAP_INDEX = GROUP_INDEX * NUMBER_OF_UNITS + u;

        if (MAP_INDEX < NUMBER_OF_IFM)
        begin : g_ram
            dual_port_ram #(
                .DATA_WIDTH (DATA_WIDTH),
                .IFM_SIZE   (IFM_SIZE)
            )
            u_dual_port_ram (
                .clk       (clk),
                .arst_n    (arst_n),
                .wr_en     (wr_en),
                .rd_en_a   (rd_en_a),
                .addr_a    (addr_a),
                .wr_data   (wr_data[u]),
                .rd_en_b   (rd_en_b),
                .addr_b    (addr_b),
                .rd_data_a (rd_data_a[u]),
                .rd_data_b (rd_data_b[u])
            );
        end
        else
        begin : g_missing
            // no map behind this lane, so it always reads as zero.
            assign rd_data_a[u] = '0;
            assign rd_data_b[u] = '0;
        end
    end

endmodule

// File: design/ifm_buffer_array.sv
module ifm_buffer_array #(
    parameter int DATA_WIDTH = ifm_buffer_pkg::DEFAULT_DATA_WIDTH,
    parameter int IFM_SIZE = ifm_buffer_pkg::DEFAULT_IFM_SIZE,
    parameter int NUMBER_OF_IFM = ifm_buffer_pkg::DEFAULT_NUMBER_OF_IFM,
    parameter int NUMBER_OF_UNITS = ifm_buffer_pkg::DEFAULT_NUMBER_OF_UNITS,
    localparam int GROUPS = ifm_buffer_pkg::group_count(NUMBER_OF_IFM, NUMBER_OF_UNITS),
    localparam int SEL_WIDTH = ifm_buffer_pkg::sel_width(NUMBER_OF_IFM, NUMBER_OF_UNITS),
    localparam int ADDR_WIDTH = ifm_buffer_pkg::addr_width(IFM_SIZE)
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [SEL_WIDTH-1:0]  ifm_sel,
    input  logic                  ifm_enable_write_previous,
    input  logic                  ifm_enable_read_previous,
    input  logic [ADDR_WIDTH-1:0] ifm_address_write_previous,
    input  logic [ADDR_WIDTH-1:0] ifm_address_read_previous,
    input  logic                  ifm_enable_read_a_next,
    input  logic                  ifm_enable_read_b_next,
    input  logic [ADDR_WIDTH-1:0] ifm_address_read_a_next,
    input  logic [ADDR_WIDTH-1:0] ifm_address_read_b_next,
    input  logic [DATA_WIDTH-1:0] data_in_from_previous [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] data_out_for_previous [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] data_out_a_for_next [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] data_out_b_for_next [NUMBER_OF_UNITS]
);

    logic [GROUPS-1:0]     grp_wr_en;
    logic [GROUPS-1:0]     grp_rd_en_a;
    logic [GROUPS-1:0]     grp_rd_en_b;
    logic [ADDR_WIDTH-1:0] grp_addr_a [GROUPS];
    logic [ADDR_WIDTH-1:0] grp_addr_b [GROUPS];
    logic [DATA_WIDTH-1:0] grp_rd_data_a [GROUPS][NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] grp_rd_data_b [GROUPS][NUMBER_OF_UNITS];

    ifm_port_steer #(
        .NUMBER_OF_IFM   (NUMBER_OF_IFM),
        .NUMBER_OF_UNITS (NUMBER_OF_UNITS),
        .IFM_SIZE        (IFM_SIZE)
    )
    u_ifm_port_steer (
        .clk                        (clk),
        .arst_n                     (arst_n),
        .ifm_sel                    (ifm_sel),
        .ifm_enable_write_previous  (ifm_enable_write_previous),
        .ifm_enable_read_previous   (ifm_enable_read_previous),
        .ifm_address_write_previous (ifm_address_write_previous),
        .ifm_address_read_previous  (ifm_address_read_previous),
        .ifm_enable_read_a_next     (ifm_enable_read_a_next),
        .ifm_enable_read_b_next     (ifm_enable_read_b_next),
        .ifm_address_read_a_next    (ifm_address_read_a_next),
        .ifm_address_read_b_next    (ifm_address_read_b_next),
        .grp_wr_en                  (grp_wr_en),
        .grp_rd_en_a                (grp_rd_en_a),
        .grp_rd_en_b                (grp_rd_en_b),
        .grp_addr_a                 (grp_addr_a),
        .grp_addr_b                 (grp_addr_b)
    );

    // every group sees the write data; only the steered group stores it.
    for (genvar g = 0; g < GROUPS; g++)
    begin : g_bank
        ifm_bank_group #(
            .DATA_WIDTH      (DATA_WIDTH),
            .IFM_SIZE        (IFM_SIZE),
            .NUMBER_OF_IFM   (NUMBER_OF_IFM),
            .NUMBER_OF_UNITS (NUMBER_OF_UNITS),
            .GROUP_INDEX     (g)
        )
        u_ifm_bank_group (
            .clk       (clk),
            .arst_n    (arst_n),
            .wr_en     (grp_wr_en[g]),
            .rd_en_a   (grp_rd_en_a[g]),
            .rd_en_b   (grp_rd_en_b[g]),
            .addr_a    (grp_addr_a[g]),
            .addr_b    (grp_addr_b[g]),
            .wr_data   (data_in_from_previous),
            .rd_data_a (grp_rd_data_a[g]),
            .rd_data_b (grp_rd_data_b[g])
        );
    end

    ifm_read_mux #(
        .DATA_WIDTH      (DATA_WIDTH),
        .NUMBER_OF_IFM   (NUMBER_OF_IFM),
        .NUMBER_OF_UNITS (NUMBER_OF_UNITS)
    )
    u_ifm_read_mux (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .ifm_sel                  (ifm_sel),
        .ifm_enable_read_previous (ifm_enable_read_previous),
        .ifm_enable_read_a_next   (ifm_enable_read_a_next),
        .ifm_enable_read_b_next   (ifm_enable_read_b_next),
        .grp_rd_data_a            (grp_rd_data_a),
        .grp_rd_data_b            (grp_rd_data_b),
        .data_out_for_previous    (data_out_for_previous),
        .data_out_a_for_next      (data_out_a_for_next),
        .data_out_b_for_next      (data_out_b_for_next)
    );

endmodule

// File: design/ifm_buffer_pkg.sv
package ifm_buffer_pkg;

    localparam int DEFAULT_DATA_WIDTH = 32;
    localparam int DEFAULT_IFM_SIZE = 14;
    localparam int DEFAULT_NUMBER_OF_IFM = 16;
    localparam int DEFAULT_NUMBER_OF_UNITS = 3;

    // number of bank groups; the last one may be only partly filled.
    function automatic int group_count(input int number_of_ifm, input int number_of_units);
        return (number_of_ifm + number_of_units - 1) / number_of_units;
    endfunction

    function automatic int sel_width(input int number_of_ifm, input int number_of_units);
        int groups;
        groups = group_count(number_of_ifm, number_of_units);
        if (groups > 1)
            return $clog2(groups);
        return 1;
    endfunction

    // one map holds ifm_size squared words.
    function automatic int addr_width(input int ifm_size);
        int depth;
        depth = ifm_size * ifm_size;
        if (depth > 1)
            return $clog2(depth);
        return 1;
    endfunction

endpackage

// File: design/ifm_port_steer.sv
module ifm_port_steer #(
    parameter int NUMBER_OF_IFM = ifm_buffer_pkg::DEFAULT_NUMBER_OF_IFM,
    parameter int NUMBER_OF_UNITS = ifm_buffer_pkg::DEFAULT_NUMBER_OF_UNITS,
    parameter int IFM_SIZE = ifm_buffer_pkg::DEFAULT_IFM_SIZE,
    localparam int GROUPS = ifm_buffer_pkg::group_count(NUMBER_OF_IFM, NUMBER_OF_UNITS),
    localparam int SEL_WIDTH = ifm_buffer_pkg::sel_width(NUMBER_OF_IFM, NUMBER_OF_UNITS),
    localparam int ADDR_WIDTH = ifm_buffer_pkg::addr_width(IFM_SIZE)
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [SEL_WIDTH-1:0]  ifm_sel,
    input  logic                  ifm_enable_write_previous,
    input  logic                  ifm_enable_read_previous,
    input  logic [ADDR_WIDTH-1:0] ifm_address_write_previous,
    input  logic [ADDR_WIDTH-1:0] ifm_address_read_previous,
    input  logic                  ifm_enable_read_a_next,
    input  logic                  ifm_enable_read_b_next,
    input  logic [ADDR_WIDTH-1:0] ifm_address_read_a_next,
    input  logic [ADDR_WIDTH-1:0] ifm_address_read_b_next,
    output logic [GROUPS-1:0]     grp_wr_en,
    output logic [GROUPS-1:0]     grp_rd_en_a,
    output logic [GROUPS-1:0]     grp_rd_en_b,
    output logic [ADDR_WIDTH-1:0] grp_addr_a [GROUPS],
    output logic [ADDR_WIDTH-1:0] grp_addr_b [GROUPS]
);

    logic [SEL_WIDTH-1:0] next_sel;
    logic                 any_en;

    // the next layer works on the group filled before the current one.
    assign next_sel = (ifm_sel == '0) ? SEL_WIDTH'(GROUPS - 1) : ifm_sel - 1'b1;

    for (genvar g = 0; g < GROUPS; g++)
    begin : g_group
        logic prev_hit;
        logic next_hit;

        assign prev_hit = (ifm_sel == SEL_WIDTH'(g));
        assign next_hit = (next_sel == SEL_WIDTH'(g));

        assign grp_wr_en[g] = prev_hit & ifm_enable_write_previous;
        assign grp_rd_en_a[g] = next_hit & ifm_enable_read_a_next;
        assign grp_rd_en_b[g] = (prev_hit & ifm_enable_read_previous)
                              | (next_hit & ifm_enable_read_b_next);

        // the previous layer owns both ports of its own group.
        assign grp_addr_a[g] = prev_hit ? ifm_address_write_previous : ifm_address_read_a_next;
        assign grp_addr_b[g] = prev_hit ? ifm_address_read_previous : ifm_address_read_b_next;
    end

    assign any_en = ifm_enable_write_previous | ifm_enable_read_previous
                  | ifm_enable_read_a_next | ifm_enable_read_b_next;

    a_sel_in_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        any_en |-> (ifm_sel < GROUPS)
    )
    else
        $error("ifm_sel %0d selects no bank group", ifm_sel);

endmodule

// File: design/ifm_read_mux.sv
module ifm_read_mux #(
    parameter int DATA_WIDTH = ifm_buffer_pkg::DEFAULT_DATA_WIDTH,
    parameter int NUMBER_OF_IFM = ifm_buffer_pkg::DEFAULT_NUMBER_OF_IFM,
    parameter int NUMBER_OF_UNITS = ifm_buffer_pkg::DEFAULT_NUMBER_OF_UNITS,
    localparam int GROUPS = ifm_buffer_pkg::group_count(NUMBER_OF_IFM, NUMBER_OF_UNITS),
    localparam int SEL_WIDTH = ifm_buffer_pkg::sel_width(NUMBER_OF_IFM, NUMBER_OF_UNITS)
)
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [SEL_WIDTH-1:0]  ifm_sel,
    input  logic                  ifm_enable_read_previous,
    input  logic                  ifm_enable_read_a_next,
    input  logic                  ifm_enable_read_b_next,
    input  logic [DATA_WIDTH-1:0] grp_rd_data_a [GROUPS][NUMBER_OF_UNITS],
    input  logic [DATA_WIDTH-1:0] grp_rd_data_b [GROUPS][NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] data_out_for_previous [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] data_out_a_for_next [NUMBER_OF_UNITS],
    output logic [DATA_WIDTH-1:0] data_out_b_for_next [NUMBER_OF_UNITS]
);

    logic [SEL_WIDTH-1:0] sel_prev_q;
    logic [SEL_WIDTH-1:0] sel_next_a_q;
    logic [SEL_WIDTH-1:0] sel_next_b_q;
    logic [SEL_WIDTH-1:0] grp_next_a;
    logic [SEL_WIDTH-1:0] grp_next_b;
    logic                  prev_fresh_q;
    logic                  next_b_fresh_q;
    logic [DATA_WIDTH-1:0] prev_hold_q [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] next_b_hold_q [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] prev_routed [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] next_b_routed [NUMBER_OF_UNITS];

    // each port remembers the select that was live when its read was issued,
    // so the data routing follows the ram output register and not ifm_sel.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sel_prev_q <= '0;
            sel_next_a_q <= '0;
            sel_next_b_q <= '0;
        end
        else
        begin
            if (ifm_enable_read_previous)
                sel_prev_q <= ifm_sel;
            if (ifm_enable_read_a_next)
                sel_next_a_q <= ifm_sel;
            if (ifm_enable_read_b_next)
                sel_next_b_q <= ifm_sel;
        end
    end

    // port b of a group serves both layers, so each b-side output keeps its last
    // word and shows the ram register only in the cycle after its own read.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prev_fresh_q <= 1'b0;
            next_b_fresh_q <= 1'b0;
            for (int u = 0; u < NUMBER_OF_UNITS; u++)
            begin
                prev_hold_q[u] <= '0;
                next_b_hold_q[u] <= '0;
            end
        end
        else
        begin
            prev_fresh_q <= ifm_enable_read_previous;
            next_b_fresh_q <= ifm_enable_read_b_next;
            for (int u = 0; u < NUMBER_OF_UNITS; u++)
            begin
                prev_hold_q[u] <= data_out_for_previous[u];
                next_b_hold_q[u] <= data_out_b_for_next[u];
            end
        end
    end

    assign grp_next_a = (sel_next_a_q == '0) ? SEL_WIDTH'(GROUPS - 1) : sel_next_a_q - 1'b1;
    assign grp_next_b = (sel_next_b_q == '0) ? SEL_WIDTH'(GROUPS - 1) : sel_next_b_q - 1'b1;

    always_comb
    begin
        for (int u = 0; u < NUMBER_OF_UNITS; u++)
        begin
            prev_routed[u] = '0;
            data_out_a_for_next[u] = '0;
            next_b_routed[u] = '0;
        end
        for (int g = 0; g < GROUPS; g++)
        begin
            for (int u = 0; u < NUMBER_OF_UNITS; u++)
            begin
                if (sel_prev_q == SEL_WIDTH'(g))
                    prev_routed[u] = grp_rd_data_b[g][u];
                if (grp_next_a == SEL_WIDTH'(g))
                    data_out_a_for_next[u] = grp_rd_data_a[g][u];
                if (grp_next_b == SEL_WIDTH'(g))
                    next_b_routed[u] = grp_rd_data_b[g][u];
            end
        end
        for (int u = 0; u < NUMBER_OF_UNITS; u++)
        begin
            data_out_for_previous[u] = prev_fresh_q ? prev_routed[u] : prev_hold_q[u];
            data_out_b_for_next[u] = next_b_fresh_q ? next_b_routed[u] : next_b_hold_q[u];
        end
    end

endmodule

// File: project.f
+incdir+include
design/ifm_buffer_pkg.sv
design/dual_port_ram.sv
design/ifm_port_steer.sv
design/ifm_bank_group.sv
design/ifm_read_mux.sv
design/ifm_buffer_array.sv
verification/tb_ifm_buffer_array.sv

// File: run.sh
#!/bin/sh
# Builds the IFM buffer testbench with Verilator, runs it and checks the result.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_ifm_buffer_array -f project.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ifm_buffer_array)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: include/ifm_tb_tasks.svh
`ifndef IFM_TB_TASKS_SVH
`define IFM_TB_TASKS_SVH

// one entry per real map, indexed by map number and word address.
logic [DATA_WIDTH-1:0] model_mem [NUMBER_OF_IFM][DEPTH];
int error_count = 0;
int timeout_count = 0;

// the next layer reads the group filled before the current one.
function automatic int next_group(input int sel);
    if (sel == 0)
        return GROUPS - 1;
    return sel - 1;
endfunction

// lanes with no map behind them always read as zero.
function automatic logic [DATA_WIDTH-1:0] model_word(input int group, input int lane,
                                                     input int addr);
    int map;
    map = group * NUMBER_OF_UNITS + lane;
    if (map >= NUMBER_OF_IFM)
        return '0;
    return model_mem[map][addr];
endfunction

function automatic void record_write(input int group, input int lane, input int addr,
                                     input logic [DATA_WIDTH-1:0] word);
    int map;
    map = group * NUMBER_OF_UNITS + lane;
    if (map < NUMBER_OF_IFM)
        model_mem[map][addr] = word;
endfunction

task automatic report_mismatch(input string port, input int lane,
                               input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
    error_count++;
    $display("Fail %s %s lane %0d expected 0x%h actual 0x%h",
             test_name, port, lane, expected, actual);
endtask

task automatic wait_cycles(input int count);
    for (int i = 0; i < count; i++)
        @(posedge clk);
endtask

// drives one full set of inputs on the next rising edge, with fresh random lane data.
task automatic drive_cycle(input int sel, input logic wr, input int wr_addr,
                           input logic rd_prev, input int prev_addr,
                           input logic rd_next, input int a_addr, input int b_addr);
    @(posedge clk);
    ifm_sel <= SEL_WIDTH'(sel);
    ifm_enable_write_previous <= wr;
    ifm_address_write_previous <= ADDR_WIDTH'(wr_addr);
    ifm_enable_read_previous <= rd_prev;
    ifm_address_read_previous <= ADDR_WIDTH'(prev_addr);
    ifm_enable_read_a_next <= rd_next;
    ifm_enable_read_b_next <= rd_next;
    ifm_address_read_a_next <= ADDR_WIDTH'(a_addr);
    ifm_address_read_b_next <= ADDR_WIDTH'(b_addr);
    for (int u = 0; u < NUMBER_OF_UNITS; u++)
        data_in_from_previous[u] <= DATA_WIDTH'($urandom());
endtask

`endif

// File: verification/tb_ifm_buffer_array.sv
module tb_ifm_buffer_array;

    localparam int DATA_WIDTH = ifm_buffer_pkg::DEFAULT_DATA_WIDTH;
    localparam int IFM_SIZE = ifm_buffer_pkg::DEFAULT_IFM_SIZE;
    localparam int NUMBER_OF_IFM = ifm_buffer_pkg::DEFAULT_NUMBER_OF_IFM;
    localparam int NUMBER_OF_UNITS = ifm_buffer_pkg::DEFAULT_NUMBER_OF_UNITS;
    localparam int GROUPS = (NUMBER_OF_IFM + NUMBER_OF_UNITS - 1) / NUMBER_OF_UNITS;
    localparam int SEL_WIDTH = (GROUPS > 1) ? $clog2(GROUPS) : 1;
    localparam int DEPTH = IFM_SIZE * IFM_SIZE;
    localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [31:0] SEED = 32'hf2f4fd2f;

    logic                  clk;
    logic                  arst_n;
    logic [SEL_WIDTH-1:0]  ifm_sel;
    logic                  ifm_enable_write_previous;
    logic                  ifm_enable_read_previous;
    logic [ADDR_WIDTH-1:0] ifm_address_write_previous;
    logic [ADDR_WIDTH-1:0] ifm_address_read_previous;
    logic                  ifm_enable_read_a_next;
    logic                  ifm_enable_read_b_next;
    logic [ADDR_WIDTH-1:0] ifm_address_read_a_next;
    logic [ADDR_WIDTH-1:0] ifm_address_read_b_next;
    logic [DATA_WIDTH-1:0] data_in_from_previous [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] data_out_for_previous [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] data_out_a_for_next [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] data_out_b_for_next [NUMBER_OF_UNITS];

    // expected words and check flags line up with the cycle the output is valid.
    logic                  reset_check;
    logic                  check_prev;
    logic                  check_next_a;
    logic                  check_next_b;
    logic                  hold_prev;
    logic                  hold_next_a;
    logic                  hold_next_b;
    logic [DATA_WIDTH-1:0] exp_prev [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] exp_next_a [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] exp_next_b [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] last_prev [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] last_next_a [NUMBER_OF_UNITS];
    logic [DATA_WIDTH-1:0] last_next_b [NUMBER_OF_UNITS];
    string                 test_name;

    `include "ifm_tb_tasks.svh"

    ifm_buffer_array #(
        .DATA_WIDTH      (DATA_WIDTH),
        .IFM_SIZE        (IFM_SIZE),
        .NUMBER_OF_IFM   (NUMBER_OF_IFM),
        .NUMBER_OF_UNITS (NUMBER_OF_UNITS)
    )
    u_ifm_buffer_array (
        .clk                        (clk),
        .arst_n                     (arst_n),
        .ifm_sel                    (ifm_sel),
        .ifm_enable_write_previous  (ifm_enable_write_previous),
        .ifm_enable_read_previous   (ifm_enable_read_previous),
        .ifm_address_write_previous (ifm_address_write_previous),
        .ifm_address_read_previous  (ifm_address_read_previous),
        .ifm_enable_read_a_next     (ifm_enable_read_a_next),
        .ifm_enable_read_b_next     (ifm_enable_read_b_next),
        .ifm_address_read_a_next    (ifm_address_read_a_next),
        .ifm_address_read_b_next    (ifm_address_read_b_next),
        .data_in_from_previous      (data_in_from_previous),
        .data_out_for_previous      (data_out_for_previous),
        .data_out_a_for_next        (data_out_a_for_next),
        .data_out_b_for_next        (data_out_b_for_next)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        check_prev <= arst_n & ifm_enable_read_previous;
        check_next_a <= arst_n & ifm_enable_read_a_next;
        check_next_b <= arst_n & ifm_enable_read_b_next;
        hold_prev <= arst_n & ~ifm_enable_read_previous;
        hold_next_a <= arst_n & ~ifm_enable_read_a_next;
        hold_next_b <= arst_n & ~ifm_enable_read_b_next;
    end

    for (genvar u = 0; u < NUMBER_OF_UNITS; u++)
    begin : g_lane
        // the model lookup runs before this lane's write is recorded, as in the RAM.
        always @(posedge clk)
        begin
            if (ifm_enable_read_previous)
                exp_prev[u] <= model_word(int'(ifm_sel), u, int'(ifm_address_read_previous));
            if (ifm_enable_read_a_next)
                exp_next_a[u] <= model_word(next_group(int'(ifm_sel)), u,
                                            int'(ifm_address_read_a_next));
            if (ifm_enable_read_b_next)
                exp_next_b[u] <= model_word(next_group(int'(ifm_sel)), u,
                                            int'(ifm_address_read_b_next));
            last_prev[u] <= data_out_for_previous[u];
            last_next_a[u] <= data_out_a_for_next[u];
            last_next_b[u] <= data_out_b_for_next[u];
            if (arst_n && ifm_enable_write_previous)
                record_write(int'(ifm_sel), u, int'(ifm_address_write_previous),
                             data_in_from_previous[u]);
        end

        a_reset_zero : assert property (@(posedge clk) reset_check |->
            (data_out_for_previous[u] == '0 && data_out_a_for_next[u] == '0
             && data_out_b_for_next[u] == '0))
        else
            report_mismatch("all ports", u, '0, $sampled(data_out_for_previous[u])
                            | $sampled(data_out_a_for_next[u]) | $sampled(data_out_b_for_next[u]));

        a_prev_read : assert property (@(posedge clk) disable iff (!arst_n)
            check_prev |-> data_out_for_previous[u] == exp_prev[u])
        else
            report_mismatch("previous", u, $sampled(exp_prev[u]), $sampled(data_out_for_previous[u]));

        a_next_a_read : assert property (@(posedge clk) disable iff (!arst_n)
            check_next_a |-> data_out_a_for_next[u] == exp_next_a[u])
        else
            report_mismatch("next a", u, $sampled(exp_next_a[u]), $sampled(data_out_a_for_next[u]));

        a_next_b_read : assert property (@(posedge clk) disable iff (!arst_n)
            check_next_b |-> data_out_b_for_next[u] == exp_next_b[u])
        else
            report_mismatch("next b", u, $sampled(exp_next_b[u]), $sampled(data_out_b_for_next[u]));

        // an output keeps its word through any cycle without a read on its own port.
        a_hold_prev : assert property (@(posedge clk) disable iff (!arst_n)
            hold_prev |-> data_out_for_previous[u] == last_prev[u])
        else
            report_mismatch("hold previous", u, $sampled(last_prev[u]),
                            $sampled(data_out_for_previous[u]));

        a_hold_next_a : assert property (@(posedge clk) disable iff (!arst_n)
            hold_next_a |-> data_out_a_for_next[u] == last_next_a[u])
        else
            report_mismatch("hold next a", u, $sampled(last_next_a[u]),
                            $sampled(data_out_a_for_next[u]));

        a_hold_next_b : assert property (@(posedge clk) disable iff (!arst_n)
            hold_next_b |-> data_out_b_for_next[u] == last_next_b[u])
        else
            report_mismatch("hold next b", u, $sampled(last_next_b[u]),
                            $sampled(data_out_b_for_next[u]));
    end

    task automatic report_and_finish();
        $display("checks done with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic wait_for_clear_outputs(input int limit);
        int  cycles;
        logic busy;
        cycles = 0;
        busy = 1'b1;
        while (busy && cycles < limit)
        begin
            @(posedge clk);
            busy = 1'b0;
            for (int u = 0; u < NUMBER_OF_UNITS; u++)
                if (data_out_for_previous[u] != '0 || data_out_a_for_next[u] != '0
                    || data_out_b_for_next[u] != '0)
                    busy = 1'b1;
            cycles++;
        end
        if (busy)
        begin
            timeout_count++;
            $display("timeout: outputs were still not zero %0d cycles after reset", limit);
        end
    endtask

    initial
    begin
        int a;
        int b;
        int s;
        int written [$];
        void'($urandom(SEED));
        test_name = "reset";
        arst_n = 1'b0;
        reset_check = 1'b0;
        ifm_sel = '0;
        ifm_enable_write_previous = 1'b0;
        ifm_enable_read_previous = 1'b0;
        ifm_address_write_previous = '0;
        ifm_address_read_previous = '0;
        ifm_enable_read_a_next = 1'b0;
        ifm_enable_read_b_next = 1'b0;
        ifm_address_read_a_next = '0;
        ifm_address_read_b_next = '0;
        for (int u = 0; u < NUMBER_OF_UNITS; u++)
            data_in_from_previous[u] = '0;
        wait_cycles(2);
        reset_check <= 1'b1;
        wait_cycles(8);
        arst_n <= 1'b1;
        wait_for_clear_outputs(4);
        wait_cycles(2);
        reset_check <= 1'b0;

        // fill every word of each group, overwrite some, then read those back.
        test_name = "previous readback";
        for (s = 0; s < GROUPS; s++)
        begin
            for (a = 0; a < DEPTH; a++)
                drive_cycle(s, 1'b1, a, 1'b0, 0, 1'b0, 0, 0);
            written.delete();
            for (int i = 0; i < 24; i++)
            begin
                a = $urandom_range(DEPTH - 1);
                written.push_back(a);
                drive_cycle(s, 1'b1, a, 1'b0, 0, 1'b0, 0, 0);
            end
            foreach (written[i])
                drive_cycle(s, 1'b0, 0, 1'b1, written[i], 1'b0, 0, 0);
            drive_cycle(s, 1'b0, 0, 1'b0, 0, 1'b0, 0, 0);
        end

        // the current group keeps taking writes while the group before it is read.
        test_name = "next read rotation";
        s = GROUPS - 1;
        for (int step = 0; step < GROUPS; step++)
        begin
            s = (s + 1) % GROUPS;
            for (int i = 0; i < 16; i++)
            begin
                a = $urandom_range(DEPTH - 1);
                b = (a + 1 + int'($urandom_range(DEPTH - 2))) % DEPTH;
                drive_cycle(s, 1'b1, $urandom_range(DEPTH - 1), 1'b0, 0, 1'b1, a, b);
            end
            drive_cycle(s, 1'b0, 0, 1'b0, 0, 1'b0, 0, 0);
        end

        test_name = "isolation";
        for (s = 0; s < GROUPS; s++)
            for (int i = 0; i < 8; i++)
                drive_cycle(s, 1'b0, 0, 1'b1, $urandom_range(DEPTH - 1), 1'b0, 0, 0);

        test_name = "hold and select change";
        drive_cycle(2, 1'b0, 0, 1'b1, $urandom_range(DEPTH - 1), 1'b1,
                    $urandom_range(DEPTH - 1), $urandom_range(DEPTH - 1));
        drive_cycle(3, 1'b0, 0, 1'b0, 0, 1'b0, 0, 0);
        wait_cycles(4);
        report_and_finish();
    end

endmodule
